/* wb_pkg.sv */
package wb_pkg;

    // Core side word
    localparam int unsigned DATA_W = 128;
    localparam int unsigned BE_W = 16;

    // Wishbone side word and beats per core word
    localparam int unsigned WB_DAT_W = 32;
    localparam int unsigned BEATS = 4;

    // Request from the write buffer to the bus master
    typedef struct packed {
        logic              write;
        logic [31:0]       addr;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;
    } mem_req_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [31:0]           adr;
        logic [WB_DAT_W-1:0]   dat;
        logic [WB_DAT_W/8-1:0] sel;
    } wb_m2s_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic [WB_DAT_W-1:0] dat;
        logic                ack;
    } wb_s2m_t;

    typedef enum logic [1:0] {
        IDLE,
        BEAT,
        DONE
    } master_state_e;

endpackage

/* wb_write_buf.sv */
`timescale 1ns/1ns

module wb_write_buf (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_req,
    input  logic                      i_write,
    input  logic [31:0]               i_addr,
    input  logic [wb_pkg::DATA_W-1:0] i_wdata,
    input  logic [wb_pkg::BE_W-1:0]   i_be,
    output logic [wb_pkg::DATA_W-1:0] o_rdata,
    output logic                      o_ack,
    output logic                      o_valid,
    input  logic                      i_accepted,
    output wb_pkg::mem_req_t          o_req,
    input  logic [wb_pkg::DATA_W-1:0] i_rdata,
    input  logic                      i_rdata_valid
);

    wb_pkg::mem_req_t slot_r [2];
    wb_pkg::mem_req_t core_req;

    logic [1:0] used_r;
    logic       wp_r;
    logic       rp_r;
    logic       busy_reading_r;
    logic       wait_rdata_r;
    logic       ack_owed_r;

    logic in_wreq;
    logic push;
    logic pop;
    logic direct_ack;

    // Reads always fetch the full word
    always_comb begin
        core_req.write = i_write;
        core_req.addr  = i_addr;
        core_req.wdata = i_wdata;
        core_req.be    = i_write ? i_be : '1;
    end

    assign in_wreq = i_req && i_write;

    // Oldest buffered entry handed to the master
    assign pop = o_valid && i_accepted && (used_r != 2'd0);

    // Capture a write the master cannot take this cycle, once per held request
    assign push = in_wreq && !ack_owed_r && !busy_reading_r &&
                  ((used_r == 2'd1) || ((used_r == 2'd0) && !i_accepted));

    // Empty buffer: master takes it or a slot does, either way ack now
    assign direct_ack = in_wreq && !busy_reading_r && (used_r == 2'd0);

    assign o_req   = (used_r != 2'd0) ? slot_r[rp_r] : core_req;
    assign o_valid = ((used_r != 2'd0) || i_req) && !wait_rdata_r;
    assign o_rdata = i_rdata;

    assign o_ack = direct_ack ||
                   (i_req && !i_write && i_rdata_valid) ||
                   (ack_owed_r && pop);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            used_r <= 2'd0;
            wp_r   <= 1'b0;
            rp_r   <= 1'b0;
        end else begin
            if (push && !pop) begin
                used_r <= used_r + 2'd1;
            end else if (pop && !push) begin
                used_r <= used_r - 2'd1;
            end
            if (push) begin
                wp_r <= !wp_r;
            end
            if (pop) begin
                rp_r <= !rp_r;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (push) begin
            slot_r[wp_r] <= core_req;
        end
    end

    // Write captured behind an older entry is acked when an entry drains
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ack_owed_r <= 1'b0;
        end else if (ack_owed_r && pop) begin
            ack_owed_r <= 1'b0;
        end else if (push && !direct_ack) begin
            ack_owed_r <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            busy_reading_r <= 1'b0;
            wait_rdata_r   <= 1'b0;
        end else if (i_rdata_valid) begin
            busy_reading_r <= 1'b0;
            wait_rdata_r   <= 1'b0;
        end else if (o_valid && !o_req.write) begin
            busy_reading_r <= 1'b1;
            if (i_accepted) begin
                wait_rdata_r <= 1'b1;
            end
        end
    end

    // Occupancy bounded and in step with the pointers
    a_used_max: assert property (@(posedge i_clk) disable iff (i_reset)
        (used_r <= 2'd2) && ((used_r == 2'd1) == (wp_r != rp_r)));

    // Read ack only comes with data back from the master
    a_read_ack: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_ack && !i_write) |-> i_rdata_valid);

endmodule

/* wb_bus_master.sv */
`timescale 1ns/1ns

module wb_bus_master (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_valid,
    input  wb_pkg::mem_req_t          i_req,
    output logic                      o_accepted,
    output logic [wb_pkg::DATA_W-1:0] o_rdata,
    output logic                      o_rdata_valid,
    output wb_pkg::wb_m2s_t           o_wb,
    input  wb_pkg::wb_s2m_t           i_wb
);

    localparam int unsigned BEAT_W = $clog2(wb_pkg::BEATS);
    localparam int unsigned SEL_W = wb_pkg::WB_DAT_W / 8;

    wb_pkg::master_state_e state_r;
    logic [BEAT_W-1:0]     beat_r;
    wb_pkg::mem_req_t      req_r;
    logic [wb_pkg::DATA_W-1:0] rdata_r;

    assign o_accepted    = (state_r == wb_pkg::IDLE);
    assign o_rdata_valid = (state_r == wb_pkg::DONE) && !req_r.write;
    assign o_rdata       = rdata_r;

    // Beat k covers bytes 4k..4k+3 of the line
    always_comb begin
        o_wb.cyc = (state_r == wb_pkg::BEAT);
        o_wb.stb = (state_r == wb_pkg::BEAT);
        o_wb.we  = req_r.write;
        o_wb.adr = {req_r.addr[31:4], beat_r, 2'b00};
        o_wb.dat = req_r.wdata[beat_r*wb_pkg::WB_DAT_W +: wb_pkg::WB_DAT_W];
        o_wb.sel = req_r.be[beat_r*SEL_W +: SEL_W];
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_r <= wb_pkg::IDLE;
            beat_r  <= '0;
        end else begin
            case (state_r)
                wb_pkg::IDLE: begin
                    if (i_valid) begin
                        state_r <= wb_pkg::BEAT;
                        beat_r  <= '0;
                    end
                end
                wb_pkg::BEAT: begin
                    if (i_wb.ack) begin
                        if (beat_r == BEAT_W'(wb_pkg::BEATS - 1)) begin
                            state_r <= wb_pkg::DONE;
                        end
                        beat_r <= beat_r + 1'b1;
                    end
                end
                wb_pkg::DONE: begin
                    state_r <= wb_pkg::IDLE;
                end
                default: begin
                    state_r <= wb_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_accepted && i_valid) begin
            req_r <= i_req;
        end
    end

    // Beats arrive low word first, shift in from the top
    always_ff @(posedge i_clk) begin
        if ((state_r == wb_pkg::BEAT) && i_wb.ack) begin
            rdata_r <= {i_wb.dat, rdata_r[wb_pkg::DATA_W-1:wb_pkg::WB_DAT_W]};
        end
    end

    // Reads always strobe all four byte lanes
    a_stb_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
        o_wb.stb |-> (o_wb.cyc && (o_wb.we || (o_wb.sel == '1))));

    // Classic cycle: everything held until the slave acks one cycle later
    a_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_wb.stb && !i_wb.ack) |=> ($stable(o_wb) && i_wb.ack));

endmodule

/* wb_sram.sv */
`timescale 1ns/1ns

module wb_sram #(
    parameter int unsigned ADDR_BITS = 10
) (
    input  logic            i_clk,
    input  logic            i_reset,
    input  wb_pkg::wb_m2s_t i_wb,
    output wb_pkg::wb_s2m_t o_wb
);

    localparam int unsigned SEL_W = wb_pkg::WB_DAT_W / 8;

    logic [wb_pkg::WB_DAT_W-1:0] mem_r [2**ADDR_BITS];
    logic [wb_pkg::WB_DAT_W-1:0] rdata_r;
    logic [ADDR_BITS-1:0]        word_addr;
    logic                        ack_r;
    logic                        start;

    assign word_addr = i_wb.adr[ADDR_BITS+1:2];

    // New access only while ack is low, so one wait state per beat
    assign start = i_wb.cyc && i_wb.stb && !ack_r;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ack_r <= 1'b0;
        end else begin
            ack_r <= start;
        end
    end

    always_ff @(posedge i_clk) begin
        if (start) begin
            if (i_wb.we) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (i_wb.sel[b]) begin
                        mem_r[word_addr][b*8 +: 8] <= i_wb.dat[b*8 +: 8];
                    end
                end
            end
            rdata_r <= mem_r[word_addr];
        end
    end

    assign o_wb.ack = ack_r;
    assign o_wb.dat = rdata_r;

    // Ack lands on the same strobe and address that started the access
    a_ack_after_stb: assert property (@(posedge i_clk) disable iff (i_reset)
        o_wb.ack |-> (i_wb.cyc && i_wb.stb && $past(i_wb.stb) && $stable(i_wb.adr)));

endmodule

/* mem_path_top.sv */
`timescale 1ns/1ns

module mem_path_top #(
    parameter int unsigned SRAM_ADDR_BITS = 10
) (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_req,
    input  logic                      i_write,
    input  logic [31:0]               i_addr,
    input  logic [wb_pkg::DATA_W-1:0] i_wdata,
    input  logic [wb_pkg::BE_W-1:0]   i_be,
    output logic [wb_pkg::DATA_W-1:0] o_rdata,
    output logic                      o_ack
);

    wb_pkg::mem_req_t          buf_req;
    logic                      buf_valid;
    logic                      mst_accepted;
    logic [wb_pkg::DATA_W-1:0] mst_rdata;
    logic                      mst_rdata_valid;
    wb_pkg::wb_m2s_t           wb_m2s;
    wb_pkg::wb_s2m_t           wb_s2m;

    wb_write_buf write_buf_inst (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_req         (i_req),
        .i_write       (i_write),
        .i_addr        (i_addr),
        .i_wdata       (i_wdata),
        .i_be          (i_be),
        .o_rdata       (o_rdata),
        .o_ack         (o_ack),
        .o_valid       (buf_valid),
        .i_accepted    (mst_accepted),
        .o_req         (buf_req),
        .i_rdata       (mst_rdata),
        .i_rdata_valid (mst_rdata_valid)
    );

    wb_bus_master bus_master_inst (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_valid       (buf_valid),
        .i_req         (buf_req),
        .o_accepted    (mst_accepted),
        .o_rdata       (mst_rdata),
        .o_rdata_valid (mst_rdata_valid),
        .o_wb          (wb_m2s),
        .i_wb          (wb_s2m)
    );

    wb_sram #(
        .ADDR_BITS (SRAM_ADDR_BITS)
    ) sram_inst (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_wb    (wb_m2s),
        .o_wb    (wb_s2m)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int unsigned PERIOD_NS    = 8,
    parameter int unsigned RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Released just after an edge, like the rest of the stimulus
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_reset = 1'b0;
    end

endmodule

/* tb_mem_path.sv */
`timescale 1ns/1ns

module tb_mem_path;

    localparam int CLK_PERIOD_NS = 8;
    localparam int DIRECTED_REQS = 17;
    localparam int RANDOM_LINES = 16;
    localparam int RANDOM_OPS = 200;
    localparam int TOTAL_REQS = DIRECTED_REQS + RANDOM_LINES + RANDOM_OPS;
    localparam int TIMEOUT_NS = TOTAL_REQS * 40 * CLK_PERIOD_NS;
    localparam int READ_LATENCY = 9;
    localparam logic [31:0] LCG_SEED = 32'h2063_ccdf;

    logic         clk;
    logic         reset;
    logic         core_req;
    logic         core_write;
    logic [31:0]  core_addr;
    logic [127:0] core_wdata;
    logic [15:0]  core_be;
    logic [127:0] core_rdata;
    logic         core_ack;

    // Shadow of the SRAM, one 128-bit line per entry
    logic [127:0] shadow [256];
    logic [127:0] exp_rdata;
    logic [31:0]  lcg_state;
    int           ack_cycles;
    int           cycle_count = 0;
    int           reads_checked;
    int           error_count;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (4)
    ) clock_gen_inst (
        .o_clk   (clk),
        .o_reset (reset)
    );

    mem_path_top #(
        .SRAM_ADDR_BITS (10)
    ) mem_path_top_inst (
        .i_clk   (clk),
        .i_reset (reset),
        .i_req   (core_req),
        .i_write (core_write),
        .i_addr  (core_addr),
        .i_wdata (core_wdata),
        .i_be    (core_be),
        .o_rdata (core_rdata),
        .o_ack   (core_ack)
    );

    task automatic value_mismatch(input string name, input logic [127:0] expected,
                                  input logic [127:0] actual);
        error_count++;
        $display("[FAIL] t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        $display("TESTS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic latency_mismatch(input string name, input int expected, input int actual);
        error_count++;
        $display("[FAIL] t=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
        $display("TESTS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic abort_run(input string reason);
        error_count++;
        $display("Error at t=%0t: %s", $time, reason);
        $display("TESTS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] line_addr(input logic [7:0] line, input logic [3:0] low);
        return {20'd0, line, low};
    endfunction

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Every read ack carries the newest shadow contents
    a_read_data: assert property (@(posedge clk)
        (core_ack && core_req && !core_write) |-> (core_rdata == exp_rdata))
        else value_mismatch("o_rdata", exp_rdata, core_rdata);

    // No ack without a request, in or out of reset
    a_no_spurious_ack: assert property (@(posedge clk)
        (cycle_count != 0 && !core_req) |-> !core_ack)
        else value_mismatch("o_ack", 128'd0, 128'd1);

    a_reset_quiet: assert property (@(posedge clk)
        (cycle_count > 1 && reset) |->
        (!mem_path_top_inst.wb_m2s.stb && !mem_path_top_inst.buf_valid))
        else abort_run("Wishbone strobe or buffer valid was high during reset");

    // Presents one request and holds it until o_ack is seen at an edge
    task automatic issue_request(input logic write, input logic [31:0] addr,
                                 input logic [127:0] wdata, input logic [15:0] be);
        int waited;
        waited     = 0;
        core_req   = 1'b1;
        core_write = write;
        core_addr  = addr;
        core_wdata = wdata;
        core_be    = be;
        @(negedge clk);
        while (!core_ack) begin
            waited++;
            @(negedge clk);
        end
        ack_cycles = waited;
        @(posedge clk);
        #1;
        core_req = 1'b0;
    endtask

    task automatic write_line(input logic [31:0] addr, input logic [127:0] data,
                              input logic [15:0] be);
        logic [7:0] idx;
        idx = addr[11:4];
        issue_request(1'b1, addr, data, be);
        for (int b = 0; b < 16; b++) begin
            if (be[b]) begin
                shadow[idx][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic read_line(input logic [31:0] addr);
        exp_rdata = shadow[addr[11:4]];
        issue_request(1'b0, addr, 128'd0, 16'h0000);
        reads_checked++;
    endtask

    task automatic idle_cycles(input int n);
        if (n > 0) begin
            repeat (n) @(posedge clk);
            #1;
        end
    endtask

    task automatic random_data(output logic [127:0] data);
        for (int w = 0; w < 4; w++) begin
            lcg_state = lcg_next(lcg_state);
            data[w*32 +: 32] = lcg_state;
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        abort_run($sformatf("watchdog expired after %0d ns, the DUT stopped acknowledging",
                            TIMEOUT_NS));
    end

    initial begin
        logic [31:0]  op;
        logic [31:0]  addr;
        logic [127:0] data;

        core_req      = 1'b0;
        core_write    = 1'b0;
        core_addr     = 32'd0;
        core_wdata    = 128'd0;
        core_be       = 16'h0000;
        exp_rdata     = 128'd0;
        lcg_state     = LCG_SEED;
        ack_cycles    = 0;
        reads_checked = 0;
        error_count   = 0;

        @(negedge reset);
        idle_cycles(3);

        // Full write, then a read from an idle path
        write_line(line_addr(8'd32, 4'd0), 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210,
                   16'hFFFF);
        assert (ack_cycles == 0) else latency_mismatch("write ack delay", 0, ack_cycles);
        idle_cycles(12);
        read_line(line_addr(8'd32, 4'd0));
        assert (ack_cycles == READ_LATENCY)
            else latency_mismatch("read ack delay", READ_LATENCY, ack_cycles);

        // Byte enable merge over an existing line
        write_line(line_addr(8'd33, 4'd0), 128'h1111_2222_3333_4444_5555_6666_7777_8888,
                   16'hFFFF);
        write_line(line_addr(8'd33, 4'd0), 128'hA0A1_A2A3_A4A5_A6A7_A8A9_AAAB_ACAD_AEAF,
                   16'hA5A5);
        write_line(line_addr(8'd33, 4'd0), 128'hB0B1_B2B3_B4B5_B6B7_B8B9_BABB_BCBD_BEBF,
                   16'h0F00);
        write_line(line_addr(8'd33, 4'd0), 128'hC0C1_C2C3_C4C5_C6C7_C8C9_CACB_CCCD_CECF,
                   16'h8001);
        read_line(line_addr(8'd33, 4'd0));

        // Three writes back to back fill the buffer
        idle_cycles(12);
        write_line(line_addr(8'd40, 4'd0), 128'h4040_0000_4040_0001_4040_0002_4040_0003,
                   16'hFFFF);
        assert (ack_cycles == 0) else latency_mismatch("first write ack delay", 0, ack_cycles);
        write_line(line_addr(8'd41, 4'd0), 128'h4141_0000_4141_0001_4141_0002_4141_0003,
                   16'hFFFF);
        write_line(line_addr(8'd42, 4'd0), 128'h4242_0000_4242_0001_4242_0002_4242_0003,
                   16'hFFFF);
        read_line(line_addr(8'd40, 4'd0));
        read_line(line_addr(8'd41, 4'd0));
        read_line(line_addr(8'd42, 4'd0));

        // Read of a line whose new data still sits in the buffer
        write_line(line_addr(8'd51, 4'd0), 128'h5151_0000_5151_0001_5151_0002_5151_0003,
                   16'hFFFF);
        idle_cycles(12);
        write_line(line_addr(8'd50, 4'd0), 128'h5050_5050_5050_5050_5050_5050_5050_5050,
                   16'hFFFF);
        write_line(line_addr(8'd51, 4'd0), 128'h5151_9999_5151_9999_5151_9999_5151_9999,
                   16'hFFFF);
        read_line(line_addr(8'd51, 4'd0));

        // Random traffic over lines 0 to 15
        for (int i = 0; i < RANDOM_LINES; i++) begin
            random_data(data);
            write_line(line_addr(8'(i), 4'd0), data, 16'hFFFF);
        end
        for (int i = 0; i < RANDOM_OPS; i++) begin
            lcg_state = lcg_next(lcg_state);
            op = lcg_state;
            addr = line_addr({4'd0, op[27:24]}, op[23:20]);
            if (op[31]) begin
                random_data(data);
                lcg_state = lcg_next(lcg_state);
                write_line(addr, data, lcg_state[31:16]);
            end else begin
                read_line(addr);
            end
            idle_cycles(int'(op[17:16]));
        end

        idle_cycles(2);
        if (error_count == 0) begin
            $display("Checked %0d reads", reads_checked);
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "Errors were found");
        end
    end

endmodule

/* sim.f */
wb_pkg.sv
wb_write_buf.sv
wb_bus_master.sv
wb_sram.sv
mem_path_top.sv
tb_clock_gen.sv
tb_mem_path.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_mem_path -o tb_mem_path

./obj_dir/tb_mem_path | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
